/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // ----------------------------------------
    // data widths
    // ----------------------------------------
    typedef logic [9:0] word_t;      // data and instruction word
    typedef logic [2:0] reg_addr_t;  // {bank, reg number}
    typedef logic [3:0] shamt_t;     // shift amount, low bits of rt

    // ----------------------------------------
    // opcodes in instr[9:7]
    // ----------------------------------------
    typedef enum logic [2:0] {
        op_rtype = 3'b000,  // add, sub, slt, nand
        op_shift = 3'b001,  // srl, sll, halt
        op_bne   = 3'b010,
        op_addi  = 3'b011,
        op_jump  = 3'b100
    } op_t;

    // ----------------------------------------
    // alu operations
    // ----------------------------------------
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_slt  = 3'd2,
        alu_nand = 3'd3,
        alu_srl  = 3'd4,
        alu_sll  = 3'd5,
        alu_pass = 3'd6   // forwards operand b
    } alu_op_t;

endpackage

/* verilog/alu.sv */
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   result,
    output logic             zero
);
    import cpu_pkg::*;

    shamt_t shamt;

    assign shamt = b[3:0];

    // ----------------------------------------
    // operation select
    // ----------------------------------------
    always_comb begin
        case (op)
            alu_add:  result = a + b;            // wraps at 10 bits
            alu_sub:  result = a - b;
            alu_slt:  result = (a < b) ? word_t'(1) : word_t'(0);
            alu_nand: result = ~(a & b);
            alu_srl: begin
                if (shamt >= 4'd10) begin
                    result = '0;                 // everything shifted out
                end else begin
                    result = a >> shamt;
                end
            end
            alu_sll: begin
                if (shamt >= 4'd10) begin
                    result = '0;
                end else begin
                    result = a << shamt;
                end
            end
            alu_pass: result = b;
            default:  result = '0;
        endcase
    end

    // bne tests this after a subtract
    assign zero = (result == '0);

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2
);
    import cpu_pkg::*;

    // two banks of four, bank bit is the address msb
    word_t regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // ----------------------------------------
    // read ports
    // ----------------------------------------
    assign rdata1 = regs[raddr1];  // rs
    assign rdata2 = regs[raddr2];  // rt

endmodule

/* verilog/pc_counter.sv */
`timescale 1ns/1ns

module pc_counter #(
    parameter int ADDR_W = 7
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              inc,
    input  logic              load,
    input  logic [ADDR_W-1:0] target,
    output logic [ADDR_W-1:0] pc
);

    // clear wins over load, load wins over inc
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (clear) begin
            pc <= '0;
        end else if (load) begin
            pc <= target;           // branch or jump
        end else if (inc) begin
            pc <= pc + ADDR_W'(1);  // wraps at the top of memory
        end
    end

    // the controller picks exactly one pc action per write cycle
    a_load_inc: assert property (@(posedge clk) disable iff (rst)
        !(load && inc));

endmodule

/* verilog/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem #(
    parameter int ADDR_W = 7
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  cpu_pkg::word_t    wdata,
    input  logic [ADDR_W-1:0] raddr,
    output cpu_pkg::word_t    rdata
);
    import cpu_pkg::*;

    word_t mem [2**ADDR_W];

    // empty slots decode as add r0,r0
    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;  // program loader
        end
        rdata <= mem[raddr];      // one-cycle fetch
    end

endmodule

/* verilog/cpu_control.sv */
`timescale 1ns/1ns

module cpu_control #(
    parameter int ADDR_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  cpu_pkg::word_t     instr,
    input  logic [ADDR_W-1:0]  pc,
    input  logic               zero,
    output logic               pc_clear,
    output logic               pc_inc,
    output logic               pc_load,
    output logic [ADDR_W-1:0]  pc_target,
    output logic               rf_we,
    output cpu_pkg::reg_addr_t rd_addr1,
    output cpu_pkg::reg_addr_t rd_addr2,
    output cpu_pkg::reg_addr_t wr_addr,
    output cpu_pkg::alu_op_t   alu_op,
    output logic               use_imm,
    output cpu_pkg::word_t     imm,
    output logic               halted,
    output logic               busy
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_write,
        st_halt
    } state_t;

    state_t            state;
    state_t            state_nxt;
    op_t               opcode;
    logic [1:0]        funct;
    logic              bank;
    logic              do_write;
    logic              is_halt;
    logic              is_bne;
    logic              is_jump;
    logic [ADDR_W-1:0] br_target;

    // ----------------------------------------
    // field decode
    // ----------------------------------------
    assign opcode   = op_t'(instr[9:7]);
    assign bank     = instr[2];
    assign funct    = instr[1:0];
    assign rd_addr1 = {bank, instr[6:5]};   // rs
    assign rd_addr2 = {bank, instr[4:3]};   // rt
    assign wr_addr  = rd_addr2;             // results always land in rt
    assign imm      = {8'b0, funct};        // zero-extended addi immediate

    always_comb begin
        alu_op   = alu_pass;
        use_imm  = 1'b0;
        do_write = 1'b0;
        is_halt  = 1'b0;
        is_bne   = 1'b0;
        is_jump  = 1'b0;
        case (opcode)
            op_rtype: begin
                do_write = 1'b1;
                case (funct)
                    2'b00:   alu_op = alu_add;
                    2'b01:   alu_op = alu_sub;
                    2'b10:   alu_op = alu_slt;
                    default: alu_op = alu_nand;
                endcase
            end
            op_shift: begin
                if (funct[1]) begin
                    is_halt = 1'b1;  // 10 and 11 both stop the core
                end else begin
                    do_write = 1'b1;
                    alu_op   = funct[0] ? alu_sll : alu_srl;
                end
            end
            op_bne: begin
                alu_op = alu_sub;    // zero flag means equal
                is_bne = 1'b1;
            end
            op_addi: begin
                alu_op   = alu_add;
                use_imm  = 1'b1;
                do_write = 1'b1;
            end
            op_jump: is_jump = 1'b1;
            default: ;               // 101..111 just advance
        endcase
    end

    // pc+1 plus sign-extended 2-bit offset wrapping at ADDR_W
    assign br_target = pc + ADDR_W'(1) + {{(ADDR_W-2){funct[1]}}, funct};
    assign pc_target = is_jump ? instr[ADDR_W-1:0] : br_target;

    // ----------------------------------------
    // strobes
    // ----------------------------------------
    assign busy     = (state == st_fetch) || (state == st_exec) || (state == st_write);
    assign halted   = (state == st_halt);
    assign pc_clear = start && !busy;
    assign rf_we    = (state == st_write) && do_write;
    assign pc_load  = (state == st_write) && (is_jump || (is_bne && !zero));
    assign pc_inc   = (state == st_write) && !pc_load;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle,
            st_halt:  if (start) state_nxt = st_fetch;
            st_fetch: state_nxt = st_exec;       // memory read registered here
            st_exec:  state_nxt = is_halt ? st_halt : st_write;
            st_write: state_nxt = st_fetch;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // side effects only in a write cycle that follows execute
    a_write_only: assert property (@(posedge clk) disable iff (rst)
        (rf_we || pc_load) |-> (state == st_write && $past(state) == st_exec));

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
    parameter int ADDR_W = 7
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_en,
    input  logic [ADDR_W-1:0]  load_addr,
    input  cpu_pkg::word_t     load_data,
    input  logic               start,
    output logic               wb_valid,
    output cpu_pkg::reg_addr_t wb_addr,
    output cpu_pkg::word_t     wb_data,
    output logic               halted,
    output logic [ADDR_W-1:0]  pc
);
    import cpu_pkg::*;

    word_t             instr;
    word_t             imm;
    word_t             rdata1;
    word_t             rdata2;
    word_t             alu_b;
    word_t             alu_result;
    alu_op_t           alu_op;
    reg_addr_t         rd_addr1;
    reg_addr_t         rd_addr2;
    reg_addr_t         wr_addr;
    logic [ADDR_W-1:0] pc_target;
    logic              pc_clear;
    logic              pc_inc;
    logic              pc_load;
    logic              rf_we;
    logic              use_imm;
    logic              zero;
    logic              busy;
    logic              mem_we;

    // ----------------------------------------
    // glue
    // ----------------------------------------
    assign mem_we   = load_en && !busy;              // no writes while running
    assign alu_b    = use_imm ? imm : rdata2;
    assign wb_valid = rf_we;
    assign wb_addr  = wr_addr;
    assign wb_data  = alu_result;

    cpu_control #(.ADDR_W(ADDR_W)) u_control (
        .clk(clk), .rst(rst), .start(start), .instr(instr), .pc(pc), .zero(zero),
        .pc_clear(pc_clear), .pc_inc(pc_inc), .pc_load(pc_load), .pc_target(pc_target),
        .rf_we(rf_we), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2), .wr_addr(wr_addr),
        .alu_op(alu_op), .use_imm(use_imm), .imm(imm), .halted(halted), .busy(busy)
    );

    pc_counter #(.ADDR_W(ADDR_W)) u_pc (
        .clk(clk), .rst(rst), .clear(pc_clear), .inc(pc_inc), .load(pc_load),
        .target(pc_target), .pc(pc)
    );

    instr_mem #(.ADDR_W(ADDR_W)) u_imem (
        .clk(clk), .we(mem_we), .waddr(load_addr), .wdata(load_data),
        .raddr(pc), .rdata(instr)
    );

    register_file u_rf (
        .clk(clk), .rst(rst), .we(rf_we), .waddr(wr_addr), .wdata(alu_result),
        .raddr1(rd_addr1), .raddr2(rd_addr2), .rdata1(rdata1), .rdata2(rdata2)
    );

    alu u_alu (
        .a(rdata1), .b(alu_b), .op(alu_op), .result(alu_result), .zero(zero)
    );

endmodule

/* sim/cpu_checker.sv */
`timescale 1ns/1ns

module cpu_checker #(
    parameter int ADDR_W = 7,
    parameter int MAX_WB = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               run_end,
    input  logic               wb_valid,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data,
    input  logic               halted,
    input  logic [ADDR_W-1:0]  pc,
    input  cpu_pkg::reg_addr_t exp_addr [MAX_WB],
    input  cpu_pkg::word_t     exp_data [MAX_WB],
    input  int                 exp_count,
    input  logic [ADDR_W-1:0]  exp_pc,
    output int                 value_errors,
    output int                 count_errors,
    output int                 halt_errors
);
    import cpu_pkg::*;

    int   wb_idx;
    logic halted_q;
    logic start_q;

    // ----------------------------------------
    // write-back and halt compare
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            wb_idx       = 0;
            halted_q     = 1'b0;
            start_q      = 1'b0;
            value_errors = 0;
            count_errors = 0;
            halt_errors  = 0;
        end else begin
            if (start) begin
                wb_idx = 0;  // new run, new expected list
            end
            if (wb_valid) begin
                if (wb_idx >= exp_count) begin
                    count_errors++;
                    $display("extra write-back to register %0d (data %h), only %0d expected",
                             wb_addr, wb_data, exp_count);
                end else begin
                    if (wb_addr !== exp_addr[wb_idx]) begin
                        value_errors++;
                        $display("FAIL wb_addr: got %h expected %h (write-back %0d)",
                                 wb_addr, exp_addr[wb_idx], wb_idx);
                    end
                    if (wb_data !== exp_data[wb_idx]) begin
                        value_errors++;
                        $display("FAIL wb_data: got %h expected %h (write-back %0d)",
                                 wb_data, exp_data[wb_idx], wb_idx);
                    end
                end
                wb_idx++;
            end
            if (halted && wb_valid) begin
                halt_errors++;
                $display("register write seen while the core is halted");
            end
            if (halted_q && !halted && !start_q) begin
                halt_errors++;
                $display("halted dropped without a start");
            end
            if (run_end) begin
                if (wb_idx != exp_count) begin
                    count_errors++;
                    $display("wrong number of write-backs: saw %0d, expected %0d",
                             wb_idx, exp_count);
                end
                if (pc !== exp_pc) begin
                    value_errors++;
                    $display("FAIL pc: got %h expected %h", pc, exp_pc);
                end
            end
            halted_q = halted;
            start_q  = start;
        end
    end

endmodule

/* sim/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;
    import cpu_pkg::*;

    localparam int    ADDR_W = 7;
    localparam int    N_PROG = 5;
    localparam int    ROW_W  = 24;            // words loaded per program
    localparam int    MAX_WB = 64;
    localparam int    MARGIN = 20;
    localparam word_t HALT_W = 10'b0010000010;  // shift opcode, funct 10

    logic              clk = 1'b0;
    logic              rst;
    logic              load_en;
    logic [ADDR_W-1:0] load_addr;
    word_t             load_data;
    logic              start;
    logic              run_end;
    logic              wb_valid;
    reg_addr_t         wb_addr;
    word_t             wb_data;
    logic              halted;
    logic [ADDR_W-1:0] pc;

    word_t             prog_tab [N_PROG][ROW_W];  // program table
    word_t             model_mem [2**ADDR_W];
    word_t             model_regs [8];
    reg_addr_t         exp_addr [MAX_WB];
    word_t             exp_data [MAX_WB];
    int                exp_count;
    logic [ADDR_W-1:0] exp_pc;
    int                value_errors;
    int                count_errors;
    int                halt_errors;
    int                fill_p;
    int                fill_i;
    int                cycles = 0;
    int                cycle_limit;

    always #20 clk = ~clk;

    cpu_top #(.ADDR_W(ADDR_W)) UUT (
        .clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .start(start), .wb_valid(wb_valid), .wb_addr(wb_addr),
        .wb_data(wb_data), .halted(halted), .pc(pc)
    );

    cpu_checker #(.ADDR_W(ADDR_W), .MAX_WB(MAX_WB)) u_checker (
        .clk(clk), .rst(rst), .start(start), .run_end(run_end), .wb_valid(wb_valid),
        .wb_addr(wb_addr), .wb_data(wb_data), .halted(halted), .pc(pc),
        .exp_addr(exp_addr), .exp_data(exp_data), .exp_count(exp_count), .exp_pc(exp_pc),
        .value_errors(value_errors), .count_errors(count_errors), .halt_errors(halt_errors)
    );

    task automatic report_counts(input int timeouts);
        $display("errors: %0d value, %0d count, %0d halt, %0d timeout",
                 value_errors, count_errors, halt_errors, timeouts);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: core did not halt within %0d cycles", cycle_limit);
            report_counts(1);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------
    // program table
    // ----------------------------------------
    function automatic word_t encode(input int op, input int rs, input int rt,
                                     input int bank, input int fn);
        return {op[2:0], rs[1:0], rt[1:0], bank[0], fn[1:0]};
    endfunction

    function automatic word_t jump_to(input int target);
        return {3'b100, target[6:0]};
    endfunction

    task automatic begin_prog(input int p);
        fill_p = p;
        fill_i = 0;
    endtask

    task automatic emit(input word_t w);
        prog_tab[fill_p][fill_i] = w;
        fill_i++;
    endtask

    task automatic build_table();
        for (int p = 0; p < N_PROG; p++) begin
            for (int i = 0; i < ROW_W; i++) begin
                prog_tab[p][i] = HALT_W;
            end
        end
        begin_prog(0);                  // addi chains, bank 1 kept apart
        emit(encode(3, 0, 1, 0, 3));
        emit(encode(3, 1, 1, 0, 3));
        emit(encode(3, 1, 2, 0, 2));
        emit(encode(3, 0, 1, 1, 1));
        emit(encode(3, 1, 3, 1, 3));
        emit(encode(0, 1, 2, 0, 0));
        emit(HALT_W);
        begin_prog(1);                  // alu ops in both banks, wrap-around
        emit(encode(0, 0, 3, 0, 3));    // nand gives all ones
        emit(encode(0, 3, 3, 0, 0));
        emit(encode(0, 0, 1, 0, 1));
        emit(encode(0, 0, 2, 0, 2));
        emit(encode(0, 1, 0, 0, 2));
        emit(encode(0, 1, 2, 1, 3));
        emit(encode(0, 1, 3, 1, 1));
        emit(encode(0, 3, 2, 1, 0));
        emit(encode(1, 0, 0, 0, 3));    // halt, funct 11
        begin_prog(2);                  // shifts, amounts 8, 10 and 15
        emit(encode(0, 0, 0, 0, 1));
        emit(encode(0, 0, 3, 0, 3));
        emit(encode(3, 0, 1, 0, 3));
        emit(encode(1, 3, 1, 0, 1));
        emit(encode(1, 3, 1, 0, 0));
        emit(encode(3, 0, 2, 0, 2));
        emit(encode(3, 2, 2, 0, 3));
        emit(encode(3, 2, 2, 0, 3));
        emit(encode(3, 2, 2, 0, 2));
        emit(encode(1, 3, 2, 0, 0));
        emit(encode(0, 0, 1, 0, 3));
        emit(encode(1, 3, 1, 0, 1));
        emit(HALT_W);
        begin_prog(3);                  // bne loop, forward skip, jump
        emit(encode(0, 0, 0, 0, 1));
        emit(encode(0, 1, 1, 0, 1));
        emit(encode(3, 0, 2, 0, 3));
        emit(encode(3, 1, 1, 0, 1));    // loop body at 3
        emit(encode(2, 1, 2, 0, 2));    // back to 3 while r1 != r2
        emit(encode(2, 1, 0, 0, 1));    // taken forward to 7
        emit(encode(3, 0, 3, 0, 1));
        emit(jump_to(10));
        emit(encode(3, 0, 3, 0, 2));
        emit(HALT_W);
        emit(encode(2, 0, 0, 0, 1));    // never taken
        emit(encode(3, 0, 3, 0, 3));
        emit(HALT_W);
        begin_prog(4);                  // random registers and immediates
        for (int i = 0; i < 16; i++) begin
            if (i % 4 == 3) begin
                emit(encode(0, $urandom % 4, $urandom % 4, $urandom % 2, $urandom % 4));
            end else begin
                emit(encode(3, $urandom % 4, $urandom % 4, $urandom % 2, $urandom % 4));
            end
        end
    endtask

    // ----------------------------------------
    // ISA model
    // ----------------------------------------
    task automatic run_model(output int n_exec);
        int        p;
        int        nxt;
        int        off;
        word_t     w;
        word_t     a;
        word_t     b;
        word_t     r;
        reg_addr_t rs;
        reg_addr_t rt;
        logic      wr;
        logic      done;
        p         = 0;
        n_exec    = 0;
        exp_count = 0;
        done      = 1'b0;
        while (!done && n_exec < 1000) begin
            w   = model_mem[p];
            rs  = {w[2], w[6:5]};
            rt  = {w[2], w[4:3]};
            a   = model_regs[rs];
            b   = model_regs[rt];
            off = w[1] ? int'(w[1:0]) - 4 : int'(w[1:0]);
            nxt = (p + 1) % 2**ADDR_W;
            wr  = 1'b0;
            r   = '0;
            n_exec++;
            case (w[9:7])
                3'b000: begin
                    wr = 1'b1;
                    case (w[1:0])
                        2'b00:   r = a + b;
                        2'b01:   r = a - b;
                        2'b10:   r = (a < b) ? 10'd1 : 10'd0;
                        default: r = ~(a & b);
                    endcase
                end
                3'b001: begin
                    if (w[1]) begin
                        done = 1'b1;
                    end else if (w[0]) begin
                        wr = 1'b1;
                        r  = word_t'(int'(a) * (1 << b[3:0]));  // high bits fall off
                    end else begin
                        wr = 1'b1;
                        r  = word_t'(int'(a) / (1 << b[3:0]));
                    end
                end
                3'b010: begin
                    if (a != b) begin
                        nxt = (p + 1 + off + 2**ADDR_W) % 2**ADDR_W;
                    end
                end
                3'b011: begin
                    wr = 1'b1;
                    r  = a + word_t'(w[1:0]);
                end
                3'b100:  nxt = int'(w[6:0]) % 2**ADDR_W;
                default: ;
            endcase
            if (wr && exp_count < MAX_WB) begin
                model_regs[rt]       = r;
                exp_addr[exp_count]  = rt;
                exp_data[exp_count]  = r;
                exp_count++;
            end
            if (!done) begin
                p = nxt;
            end
        end
        exp_pc = ADDR_W'(p);  // pc stays on the halt
    endtask

    task automatic run_program(input int p);
        int n_exec;
        cycle_limit += ROW_W + 8 + MARGIN;
        for (int i = 0; i < ROW_W; i++) begin
            @(negedge clk);
            load_en      = 1'b1;
            load_addr    = ADDR_W'(i);
            load_data    = prog_tab[p][i];
            model_mem[i] = prog_tab[p][i];
        end
        @(negedge clk);
        load_en = 1'b0;
        run_model(n_exec);
        cycle_limit += 3 * n_exec;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) begin
            load_en   = (p == 1);          // stray loads, core is busy
            load_addr = ADDR_W'(cycles % 8);
            load_data = HALT_W;
            @(negedge clk);
        end
        load_en = 1'b0;
        repeat (4) @(negedge clk);         // halted has to hold
        run_end = 1'b1;
        @(negedge clk);
        run_end = 1'b0;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int total;
        void'($urandom(32'h3670_6172));
        rst         = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        start       = 1'b0;
        run_end     = 1'b0;
        cycle_limit = 16 + MARGIN;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int p = 0; p < N_PROG; p++) begin
            run_program(p);                // registers carry over between runs
        end
        @(negedge clk);
        total = value_errors + count_errors + halt_errors;
        report_counts(0);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/pc_counter.sv
verilog/instr_mem.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the failure line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f sources.f \
    --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '** FAIL **' sim.log; then
    exit 1
fi
exit 0
